// ==== common/wb_bus_pkg.sv ====
/*
 * wishbone side definitions for the bridge to the sdram controller
 * holds bus widths, the bundled slave request and the read tracking
 * states; imported by the top, the slave control and both data paths
 */

`default_nettype none

package wb_bus_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  // application address, word granular
  localparam int APP_AW = 26;
  // data bus
  localparam int DW     = 32;
  // one select per byte lane
  localparam int SEL_W  = DW / 8;

  // --------------------------------------------------
  // slave request bundle
  // --------------------------------------------------
  // strobe and cycle are merged, the bridge never needs them apart
  typedef struct packed {
    logic              stb_cyc;
    logic              we;
    logic [APP_AW-1:0] addr;
    logic [DW-1:0]     data;
    logic [SEL_W-1:0]  sel;
  } wb_req_t;

  // --------------------------------------------------
  // read tracking
  // --------------------------------------------------
  // idle until a read command is queued, then wait for its data
  typedef enum logic {
    RD_IDLE      = 1'b0,
    RD_WAIT_DATA = 1'b1
  } rd_track_e;

endpackage

`default_nettype wire

// ==== common/sdr_ctrl_pkg.sv ====
/*
 * sdram controller side definitions of the bridge
 * command and write-data entries as queued towards the controller,
 * fifo depths and the request opcode; widths come from the bus package
 */

`default_nettype none

package sdr_ctrl_pkg;

  import wb_bus_pkg::*;

  // --------------------------------------------------
  // request length
  // --------------------------------------------------
  localparam int BL_W = 9;
  // every command is a single transfer
  localparam logic [BL_W-1:0] SINGLE_BURST_LEN = 9'd1;

  // --------------------------------------------------
  // fifo depths, powers of two
  // --------------------------------------------------
  localparam int CMD_DEPTH   = 4;
  localparam int WDATA_DEPTH = 8;
  localparam int RDATA_DEPTH = 4;

  // --------------------------------------------------
  // command opcode
  // --------------------------------------------------
  // value is the controller's write-not bit
  typedef enum logic {
    SDR_WRITE = 1'b0,
    SDR_READ  = 1'b1
  } sdr_op_e;

  // length, opcode and address, 36 bits
  typedef struct packed {
    logic [BL_W-1:0]   len;
    sdr_op_e           op;
    logic [APP_AW-1:0] addr;
  } sdr_cmd_t;

  // active low byte enables and data, 36 bits
  typedef struct packed {
    logic [SEL_W-1:0] en_n;
    logic [DW-1:0]    data;
  } sdr_wdata_t;

endpackage

`default_nettype wire

// ==== logic/sync_fifo.sv ====
/*
 * single clock first-word-fall-through fifo
 * the head entry is always on head_o, pop only advances it
 * full and empty are registered, so a push shows up one cycle later
 * push on full and pop on empty are ignored
 */

`default_nettype none

module sync_fifo
  import wb_bus_pkg::*;
  import sdr_ctrl_pkg::*;
#(
  parameter int WIDTH = DW,
  parameter int DEPTH = RDATA_DEPTH
) (
  input  wire logic             sdram_clk,
  input  wire logic             wb_clk_i,
  input  wire logic             push_i,
  input  wire logic [WIDTH-1:0] push_data_i,
  input  wire logic             pop_i,
  output logic      [WIDTH-1:0] head_o,
  output logic                  full_o,
  output logic                  empty_o
);

  // storage, no reset needed
  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  // occupancy, one bit wider than the pointers
  logic [$clog2(DEPTH+1)-1:0] count_q;
  logic [$clog2(DEPTH+1)-1:0] count_nxt;
  logic                       do_push;
  logic                       do_pop;

  // guard against overflow and underflow
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // --------------------------------------------------
  // occupancy
  // --------------------------------------------------
  always_comb begin
    count_nxt = count_q;
    if (do_push && !do_pop) begin
      count_nxt = count_q + 1'b1;
    end else if (do_pop && !do_push) begin
      count_nxt = count_q - 1'b1;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_o   <= 1'b0;
      empty_o  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_nxt;
      // flags follow the next occupancy
      full_o  <= (count_nxt == DEPTH);
      empty_o <= (count_nxt == 0);
    end
  end

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge sdram_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // fall-through head
  assign head_o = mem[rd_ptr_q];

endmodule

`default_nettype wire

// ==== logic/wb_slave_ctrl.sv ====
/*
 * wishbone slave handshake of the bridge, purely combinational
 * writes are acked once both request fifos have room
 * reads are acked with their data once the read fifo holds it
 * also derives every fifo push and the read-data pop
 */

`default_nettype none

module wb_slave_ctrl
  import wb_bus_pkg::*;
(
  input  wire wb_req_t wb_req_i,
  // request path status
  input  wire logic    cmd_full_i,
  input  wire logic    wdata_full_i,
  // read return path status
  input  wire logic    rd_cmd_want_i,
  input  wire logic    rd_data_avail_i,
  output logic         wb_ack_o,
  output logic         cmd_push_o,
  output logic         wdata_push_o,
  output logic         rd_cmd_pushed_o,
  output logic         rd_ack_o
);

  logic wr_req;
  logic rd_req;
  logic wr_room;

  // --------------------------------------------------
  // request decode
  // --------------------------------------------------
  assign wr_req = wb_req_i.stb_cyc & wb_req_i.we;
  assign rd_req = wb_req_i.stb_cyc & ~wb_req_i.we;
  // a write needs a slot in both fifos
  assign wr_room = ~cmd_full_i & ~wdata_full_i;

  // --------------------------------------------------
  // acknowledge
  // --------------------------------------------------
  // zero latency for writes with room
  // reads wait for returned data
  always_comb begin
    if (wr_req) begin
      wb_ack_o = wr_room;
    end else if (rd_req) begin
      wb_ack_o = rd_data_avail_i;
    end else begin
      wb_ack_o = 1'b0;
    end
  end

  // --------------------------------------------------
  // fifo strobes
  // --------------------------------------------------
  // one read command per read cycle, the read path says when
  assign rd_cmd_pushed_o = rd_cmd_want_i & ~cmd_full_i;
  // write command goes with the ack
  assign cmd_push_o      = (wr_req & wb_ack_o) | rd_cmd_pushed_o;
  assign wdata_push_o    = wr_req & wb_ack_o;
  // read data leaves at the acking edge
  assign rd_ack_o        = rd_req & wb_ack_o;

endmodule

`default_nettype wire

// ==== request/request_path.sv ====
/*
 * request path towards the sdram controller
 * queues single-transfer commands and write data with byte enables
 * sdr_req_o stays up while any command is queued
 */

`default_nettype none

module request_path
  import wb_bus_pkg::*;
  import sdr_ctrl_pkg::*;
(
  input  wire logic    sdram_clk,
  input  wire logic    wb_clk_i,
  input  wire logic    cmd_push_i,
  input  wire logic    wdata_push_i,
  input  wire wb_req_t wb_req_i,
  // controller handshake
  input  wire logic    sdr_req_ack_i,
  input  wire logic    sdr_wr_next_i,
  output sdr_cmd_t     cmd_o,
  output logic         sdr_req_o,
  output sdr_wdata_t   wdata_o,
  output logic         cmd_full_o,
  output logic         wdata_full_o
);

  sdr_cmd_t   cmd_in;
  sdr_wdata_t wdata_in;
  logic       cmd_empty;

  // --------------------------------------------------
  // command entry
  // --------------------------------------------------
  assign cmd_in.len  = SINGLE_BURST_LEN;
  assign cmd_in.op   = wb_req_i.we ? SDR_WRITE : SDR_READ;
  assign cmd_in.addr = wb_req_i.addr;

  // popped when the controller takes the request
  sync_fifo #(
    .WIDTH ($bits(sdr_cmd_t)),
    .DEPTH (CMD_DEPTH)
  ) cmd_fifo_i (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (cmd_push_i),
    .push_data_i (cmd_in),
    .pop_i       (sdr_req_ack_i),
    .head_o      (cmd_o),
    .full_o      (cmd_full_o),
    .empty_o     (cmd_empty)
  );

  // request while anything is queued
  assign sdr_req_o = ~cmd_empty;

  // --------------------------------------------------
  // write-data entry
  // --------------------------------------------------
  // controller enables are active low
  assign wdata_in.en_n = ~wb_req_i.sel;
  assign wdata_in.data = wb_req_i.data;

  // popped on each wr_next from the controller
  sync_fifo #(
    .WIDTH ($bits(sdr_wdata_t)),
    .DEPTH (WDATA_DEPTH)
  ) wdata_fifo_i (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (wdata_push_i),
    .push_data_i (wdata_in),
    .pop_i       (sdr_wr_next_i),
    .head_o      (wdata_o),
    .full_o      (wdata_full_o),
    .empty_o     ()
  );

endmodule

`default_nettype wire

// ==== response/read_return_path.sv ====
/*
 * read return path of the bridge
 * allows one read command per wishbone read cycle and buffers the
 * data coming back from the controller until the read is acked
 */

`default_nettype none

module read_return_path
  import wb_bus_pkg::*;
  import sdr_ctrl_pkg::*;
(
  input  wire logic          sdram_clk,
  input  wire logic          wb_clk_i,
  input  wire wb_req_t       wb_req_i,
  // from the slave control
  input  wire logic          rd_cmd_pushed_i,
  input  wire logic          rd_ack_i,
  // from the controller
  input  wire logic          sdr_rd_valid_i,
  input  wire logic [DW-1:0] sdr_rd_data_i,
  output logic               rd_cmd_want_o,
  output logic               rd_data_avail_o,
  output logic      [DW-1:0] rd_data_o
);

  rd_track_e state_q;
  rd_track_e state_nxt;
  logic      rd_req;
  logic      rd_empty;

  assign rd_req = wb_req_i.stb_cyc & ~wb_req_i.we;

  // --------------------------------------------------
  // outstanding read tracking
  // --------------------------------------------------
  // command wanted only once per read cycle
  assign rd_cmd_want_o = (state_q == RD_IDLE) & rd_req;

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      RD_IDLE: begin
        // command accepted into the queue
        if (rd_cmd_pushed_i) begin
          state_nxt = RD_WAIT_DATA;
        end
      end
      RD_WAIT_DATA: begin
        // data handed to the master
        if (rd_ack_i) begin
          state_nxt = RD_IDLE;
        end
      end
      default: state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
    if (wb_clk_i) begin
      state_q <= RD_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  // --------------------------------------------------
  // read data buffer
  // --------------------------------------------------
  // controller never returns more than was asked for
  sync_fifo #(
    .WIDTH (DW),
    .DEPTH (RDATA_DEPTH)
  ) rdata_fifo_i (
    .sdram_clk   (sdram_clk),
    .wb_clk_i    (wb_clk_i),
    .push_i      (sdr_rd_valid_i),
    .push_data_i (sdr_rd_data_i),
    .pop_i       (rd_ack_i),
    .head_o      (rd_data_o),
    .full_o      (),
    .empty_o     (rd_empty)
  );

  assign rd_data_avail_o = ~rd_empty;

endmodule

`default_nettype wire

// ==== logic/wb2sdrc_bridge.sv ====
/*
 * wishbone slave to sdram controller request bridge, top level
 * bundles the bus inputs and ties together slave control,
 * request path and read return path; one clock, async reset
 */

`default_nettype none

module wb2sdrc_bridge
  import wb_bus_pkg::*;
  import sdr_ctrl_pkg::*;
(
  input  wire logic              sdram_clk,
  input  wire logic              wb_clk_i,
  // --------------------------------------------------
  // wishbone slave
  // --------------------------------------------------
  input  wire logic              wb_stb_i,
  input  wire logic              wb_cyc_i,
  input  wire logic              wb_we_i,
  input  wire logic [APP_AW-1:0] wb_addr_i,
  input  wire logic [DW-1:0]     wb_dat_i,
  input  wire logic [SEL_W-1:0]  wb_sel_i,
  output logic                   wb_ack_o,
  output logic      [DW-1:0]     wb_dat_o,
  // --------------------------------------------------
  // sdram controller requests
  // --------------------------------------------------
  output logic                   sdr_req_o,
  output logic      [APP_AW-1:0] sdr_req_addr_o,
  output logic      [BL_W-1:0]   sdr_req_len_o,
  output logic                   sdr_req_wr_n_o,
  input  wire logic              sdr_req_ack_i,
  output logic      [SEL_W-1:0]  sdr_wr_en_n_o,
  output logic      [DW-1:0]     sdr_wr_data_o,
  input  wire logic              sdr_wr_next_i,
  input  wire logic              sdr_rd_valid_i,
  input  wire logic [DW-1:0]     sdr_rd_data_i
);

  wb_req_t    wb_req;
  sdr_cmd_t   cmd;
  sdr_wdata_t wdata;
  logic       cmd_full;
  logic       wdata_full;
  logic       cmd_push;
  logic       wdata_push;
  logic       rd_cmd_want;
  logic       rd_cmd_pushed;
  logic       rd_data_avail;
  logic       rd_ack;

  // bus inputs as one bundle
  assign wb_req.stb_cyc = wb_stb_i & wb_cyc_i;
  assign wb_req.we      = wb_we_i;
  assign wb_req.addr    = wb_addr_i;
  assign wb_req.data    = wb_dat_i;
  assign wb_req.sel     = wb_sel_i;

  // queue heads onto the controller ports
  assign sdr_req_addr_o = cmd.addr;
  assign sdr_req_len_o  = cmd.len;
  assign sdr_req_wr_n_o = cmd.op;
  assign sdr_wr_en_n_o  = wdata.en_n;
  assign sdr_wr_data_o  = wdata.data;

  wb_slave_ctrl wb_slave_ctrl_i (
    .wb_req_i        (wb_req),
    .cmd_full_i      (cmd_full),
    .wdata_full_i    (wdata_full),
    .rd_cmd_want_i   (rd_cmd_want),
    .rd_data_avail_i (rd_data_avail),
    .wb_ack_o        (wb_ack_o),
    .cmd_push_o      (cmd_push),
    .wdata_push_o    (wdata_push),
    .rd_cmd_pushed_o (rd_cmd_pushed),
    .rd_ack_o        (rd_ack)
  );

  request_path request_path_i (
    .sdram_clk     (sdram_clk),
    .wb_clk_i      (wb_clk_i),
    .cmd_push_i    (cmd_push),
    .wdata_push_i  (wdata_push),
    .wb_req_i      (wb_req),
    .sdr_req_ack_i (sdr_req_ack_i),
    .sdr_wr_next_i (sdr_wr_next_i),
    .cmd_o         (cmd),
    .sdr_req_o     (sdr_req_o),
    .wdata_o       (wdata),
    .cmd_full_o    (cmd_full),
    .wdata_full_o  (wdata_full)
  );

  read_return_path read_return_path_i (
    .sdram_clk       (sdram_clk),
    .wb_clk_i        (wb_clk_i),
    .wb_req_i        (wb_req),
    .rd_cmd_pushed_i (rd_cmd_pushed),
    .rd_ack_i        (rd_ack),
    .sdr_rd_valid_i  (sdr_rd_valid_i),
    .sdr_rd_data_i   (sdr_rd_data_i),
    .rd_cmd_want_o   (rd_cmd_want),
    .rd_data_avail_o (rd_data_avail),
    .rd_data_o       (wb_dat_o)
  );

endmodule

`default_nettype wire

// ==== testbench/wb2sdrc_checker.sv ====
/*
 * testbench checker for the wishbone to sdram request bridge
 * watches both sides of the dut, keeps expected command and write-data
 * queues plus a shadow memory, and counts value and protocol errors
 */

`default_nettype none

module wb2sdrc_checker
  import wb_bus_pkg::*;
(
  input  wire logic              sdram_clk,
  input  wire logic              wb_clk_i,
  input  wire logic              wb_stb_i,
  input  wire logic              wb_cyc_i,
  input  wire logic              wb_we_i,
  input  wire logic [APP_AW-1:0] wb_addr_i,
  input  wire logic [DW-1:0]     wb_dat_i,
  input  wire logic [SEL_W-1:0]  wb_sel_i,
  input  wire logic              wb_ack_i,
  input  wire logic [DW-1:0]     wb_rdat_i,
  input  wire logic              sdr_req_i,
  input  wire logic [APP_AW-1:0] sdr_addr_i,
  input  wire logic [8:0]        sdr_len_i,
  input  wire logic              sdr_wr_n_i,
  input  wire logic              sdr_req_ack_i,
  input  wire logic [SEL_W-1:0]  sdr_en_n_i,
  input  wire logic [DW-1:0]     sdr_wdat_i,
  input  wire logic              sdr_wr_next_i,
  input  wire logic              sdr_rd_valid_i,
  // table value for the current read
  input  wire logic [DW-1:0]     exp_dat_i,
  input  wire logic              done_i,
  output int                     mismatch_cnt_o,
  output int                     fault_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CMD_SLOTS = 4;
  localparam int RD_SLOTS  = 4;

  int mismatch_cnt = 0;
  int fault_cnt    = 0;

  // shadow memory holds written words only
  logic [APP_AW-1:0]     sh_addr [$];
  logic [DW-1:0]         sh_word [$];
  // {wr_n, addr} in issue order
  logic [APP_AW:0]       exp_cmd [$];
  // {en_n, data} in write order
  logic [SEL_W+DW-1:0]   exp_wd [$];
  int   rd_fill;
  int   rd_out;
  logic seen_req;
  logic rd_open;
  logic end_done;

  assign mismatch_cnt_o = mismatch_cnt;
  assign fault_cnt_o    = fault_cnt;

  task automatic log_mismatch(input string name, input logic [63:0] got,
                              input logic [63:0] want);
    $display("mismatch %s got 0x%0h expected 0x%0h at %0t", name, got, want, $time);
    mismatch_cnt++;
  endtask

  task automatic report_fault(input string what);
    $display("error: %s at %0t", what, $time);
    fault_cnt++;
  endtask

  // --------------------------------------------------
  // shadow memory
  // --------------------------------------------------
  function automatic logic [DW-1:0] byte_mask(input logic [SEL_W-1:0] sel);
    logic [DW-1:0] m;
    for (int i = 0; i < SEL_W; i++) begin
      m[8*i +: 8] = {8{sel[i]}};
    end
    return m;
  endfunction

  function automatic logic [DW-1:0] shadow_read(input logic [APP_AW-1:0] a);
    logic [DW-1:0] w;
    // untouched words follow the fill rule
    w = {{(DW-APP_AW){1'b0}}, a} ^ 32'h5a5a_0000;
    for (int i = 0; i < sh_addr.size(); i++) begin
      if (sh_addr[i] == a) begin
        w = sh_word[i];
      end
    end
    return w;
  endfunction

  task automatic shadow_write(input logic [APP_AW-1:0] a, input logic [DW-1:0] d,
                              input logic [SEL_W-1:0] sel);
    logic [DW-1:0] m;
    logic [DW-1:0] w;
    int            idx;
    m   = byte_mask(sel);
    w   = (shadow_read(a) & ~m) | (d & m);
    idx = -1;
    for (int i = 0; i < sh_addr.size(); i++) begin
      if (sh_addr[i] == a) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      sh_addr.push_back(a);
      sh_word.push_back(w);
    end else begin
      sh_word[idx] = w;
    end
  endtask

  // --------------------------------------------------
  // sampling at the rising edge
  // --------------------------------------------------
  always @(posedge sdram_clk) begin : sample
    logic [APP_AW:0]     ec;
    logic [SEL_W+DW-1:0] ew;
    int                  cmd_level;
    logic                rd_req;
    logic                wr_req;
    rd_req = wb_stb_i & wb_cyc_i & ~wb_we_i;
    wr_req = wb_stb_i & wb_cyc_i & wb_we_i;
    if (!wb_clk_i && (wb_stb_i & wb_cyc_i)) begin
      seen_req = 1'b1;
    end
    // quiet outputs until the first bus request
    if (!seen_req && (sdr_req_i || wb_ack_i)) begin
      report_fault("request or acknowledge raised before any bus request");
    end
    if (wb_clk_i) begin
      exp_cmd.delete();
      exp_wd.delete();
      rd_fill  = 0;
      rd_out   = 0;
      seen_req = 1'b0;
      rd_open  = 1'b0;
      end_done = 1'b0;
    end else begin
      cmd_level = exp_cmd.size();
      // controller takes a command
      if (sdr_req_ack_i) begin
        if (!sdr_req_i) begin
          report_fault("request acknowledged with no command queued");
        end else if (exp_cmd.size() == 0) begin
          report_fault("command issued that no bus cycle asked for");
        end else begin
          ec = exp_cmd.pop_front();
          if (sdr_wr_n_i !== ec[APP_AW]) begin
            log_mismatch("sdr_req_wr_n_o", sdr_wr_n_i, ec[APP_AW]);
          end
          if (sdr_addr_i !== ec[APP_AW-1:0]) begin
            log_mismatch("sdr_req_addr_o", sdr_addr_i, ec[APP_AW-1:0]);
          end
          if (sdr_len_i !== 9'd1) begin
            log_mismatch("sdr_req_len_o", sdr_len_i, 9'd1);
          end
          // only a bus read may bring data back
          if (ec[APP_AW]) begin
            rd_out++;
          end
        end
      end
      // controller takes write data
      if (sdr_wr_next_i) begin
        if (exp_wd.size() == 0) begin
          report_fault("write data taken while none was queued");
        end else begin
          ew = exp_wd.pop_front();
          if (sdr_en_n_i !== ew[DW +: SEL_W]) begin
            log_mismatch("sdr_wr_en_n_o", sdr_en_n_i, ew[DW +: SEL_W]);
          end
          if (sdr_wdat_i !== ew[DW-1:0]) begin
            log_mismatch("sdr_wr_data_o", sdr_wdat_i, ew[DW-1:0]);
          end
        end
      end
      // controller returns read data
      if (sdr_rd_valid_i) begin
        if (rd_fill >= RD_SLOTS) begin
          report_fault("read data returned into a full read FIFO");
        end else begin
          rd_fill++;
        end
        if (rd_out == 0) begin
          report_fault("read data returned with no read command outstanding");
        end else begin
          rd_out--;
        end
      end
      if (wb_ack_i && !(wb_stb_i && wb_cyc_i)) begin
        report_fault("acknowledge without a bus cycle");
      end
      // write accepted on the bus
      if (wr_req && wb_ack_i) begin
        if (cmd_level >= CMD_SLOTS) begin
          report_fault("write acknowledged while the command FIFO was full");
        end
        exp_cmd.push_back({1'b0, wb_addr_i});
        exp_wd.push_back({~wb_sel_i, wb_dat_i});
        shadow_write(wb_addr_i, wb_dat_i, wb_sel_i);
      end
      // one command per read cycle
      if (rd_req && !rd_open) begin
        exp_cmd.push_back({1'b1, wb_addr_i});
        rd_open = 1'b1;
      end
      if (rd_req && wb_ack_i) begin
        if (wb_rdat_i !== shadow_read(wb_addr_i)) begin
          log_mismatch("wb_dat_o", wb_rdat_i, shadow_read(wb_addr_i));
        end
        if (wb_rdat_i !== exp_dat_i) begin
          log_mismatch("wb_dat_o", wb_rdat_i, exp_dat_i);
        end
        if (rd_fill == 0) begin
          report_fault("read acknowledged before its data came back");
        end else begin
          rd_fill--;
        end
        rd_open = 1'b0;
      end
      // nothing may be left over at the end
      if (done_i && !end_done) begin
        end_done = 1'b1;
        if (exp_cmd.size() != 0) begin
          report_fault("commands expected but never issued to the controller");
        end
        if (exp_wd.size() != 0) begin
          report_fault("write data expected but never taken by the controller");
        end
        if (rd_fill != 0) begin
          report_fault("read data left in the read FIFO");
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_wb2sdrc.sv ====
/*
 * testbench top for the wishbone to sdram request bridge
 * applies a stimulus table as wishbone cycles, plays the sdram
 * controller with random delays, and reports the checker's error counts
 */

`default_nettype none

module tb_wb2sdrc
  import wb_bus_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ENTRIES = 21;
  localparam int HOLD_CYCLES = 60;

  typedef enum logic [1:0] {
    OP_WR,
    OP_RD,
    OP_HOLD
  } stim_op_e;

  typedef struct packed {
    stim_op_e          op;
    logic [APP_AW-1:0] addr;
    logic [DW-1:0]     data;
    logic [SEL_W-1:0]  sel;
    logic [7:0]        gap;
    logic [DW-1:0]     exp;
  } stim_t;

  stim_t stim [NUM_ENTRIES];
  int    n_stim = 0;

  logic              sdram_clk;
  logic              wb_clk_i;
  logic              wb_stb_i;
  logic              wb_cyc_i;
  logic              wb_we_i;
  logic [APP_AW-1:0] wb_addr_i;
  logic [DW-1:0]     wb_dat_i;
  logic [SEL_W-1:0]  wb_sel_i;
  logic              wb_ack_o;
  logic [DW-1:0]     wb_dat_o;
  logic              sdr_req_o;
  logic [APP_AW-1:0] sdr_req_addr_o;
  logic [8:0]        sdr_req_len_o;
  logic              sdr_req_wr_n_o;
  logic              sdr_req_ack_i;
  logic [SEL_W-1:0]  sdr_wr_en_n_o;
  logic [DW-1:0]     sdr_wr_data_o;
  logic              sdr_wr_next_i;
  logic              sdr_rd_valid_i;
  logic [DW-1:0]     sdr_rd_data_i;
  logic [DW-1:0]     exp_dat;
  logic              done;
  logic              hold_ack;
  logic              model_busy;
  logic [31:0]       rng = 32'hf988ffc7;
  int                mismatch_cnt;
  int                fault_cnt;
  // controller model memory, written words only
  logic [APP_AW-1:0] mem_addr [$];
  logic [DW-1:0]     mem_word [$];

  wb2sdrc_bridge wb2sdrc_bridge_i (.*);

  wb2sdrc_checker checker_i (
    .sdram_clk      (sdram_clk),
    .wb_clk_i       (wb_clk_i),
    .wb_stb_i       (wb_stb_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_we_i        (wb_we_i),
    .wb_addr_i      (wb_addr_i),
    .wb_dat_i       (wb_dat_i),
    .wb_sel_i       (wb_sel_i),
    .wb_ack_i       (wb_ack_o),
    .wb_rdat_i      (wb_dat_o),
    .sdr_req_i      (sdr_req_o),
    .sdr_addr_i     (sdr_req_addr_o),
    .sdr_len_i      (sdr_req_len_o),
    .sdr_wr_n_i     (sdr_req_wr_n_o),
    .sdr_req_ack_i  (sdr_req_ack_i),
    .sdr_en_n_i     (sdr_wr_en_n_o),
    .sdr_wdat_i     (sdr_wr_data_o),
    .sdr_wr_next_i  (sdr_wr_next_i),
    .sdr_rd_valid_i (sdr_rd_valid_i),
    .exp_dat_i      (exp_dat),
    .done_i         (done),
    .mismatch_cnt_o (mismatch_cnt),
    .fault_cnt_o    (fault_cnt)
  );

  // xorshift32 step
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 0 to 3 idle cycles
  task automatic draw_delay(output int d);
    rng = next_rand(rng);
    d   = rng[1:0];
  endtask

  function automatic logic [DW-1:0] model_read(input logic [APP_AW-1:0] a);
    logic [DW-1:0] w;
    w = 32'h5a5a_0000 ^ {{(DW-APP_AW){1'b0}}, a};
    for (int i = 0; i < mem_addr.size(); i++) begin
      if (mem_addr[i] == a) begin
        w = mem_word[i];
      end
    end
    return w;
  endfunction

  // byte lanes with a low enable are written
  task automatic model_write(input logic [APP_AW-1:0] a, input logic [DW-1:0] d,
                             input logic [SEL_W-1:0] en_n);
    logic [DW-1:0] w;
    int            idx;
    w   = model_read(a);
    idx = -1;
    for (int b = 0; b < SEL_W; b++) begin
      if (!en_n[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    for (int i = 0; i < mem_addr.size(); i++) begin
      if (mem_addr[i] == a) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      mem_addr.push_back(a);
      mem_word.push_back(w);
    end else begin
      mem_word[idx] = w;
    end
  endtask

  task automatic add_entry(input stim_op_e op, input logic [APP_AW-1:0] addr,
                           input logic [DW-1:0] data, input logic [SEL_W-1:0] sel,
                           input int gap, input logic [DW-1:0] exp);
    stim_t e;
    e.op   = op;
    e.addr = addr;
    e.data = data;
    e.sel  = sel;
    e.gap  = gap[7:0];
    e.exp  = exp;
    stim[n_stim] = e;
    n_stim++;
  endtask

  initial begin
    sdram_clk = 1'b0;
    forever #5 sdram_clk = ~sdram_clk;
  end

  // --------------------------------------------------
  // controller model
  // --------------------------------------------------
  initial begin : controller_model
    int                d;
    logic [APP_AW-1:0] a;
    logic              wr_n;
    sdr_req_ack_i  = 1'b0;
    sdr_wr_next_i  = 1'b0;
    sdr_rd_valid_i = 1'b0;
    sdr_rd_data_i  = '0;
    model_busy     = 1'b0;
    wait (wb_clk_i === 1'b0);
    forever begin
      @(negedge sdram_clk);
      if (sdr_req_o && !hold_ack) begin
        model_busy = 1'b1;
        draw_delay(d);
        repeat (d) @(negedge sdram_clk);
        while (hold_ack) @(negedge sdram_clk);
        a    = sdr_req_addr_o;
        wr_n = sdr_req_wr_n_o;
        sdr_req_ack_i = 1'b1;
        @(negedge sdram_clk);
        sdr_req_ack_i = 1'b0;
        draw_delay(d);
        repeat (d) @(negedge sdram_clk);
        // single transfer, one data beat either way
        if (!wr_n) begin
          model_write(a, sdr_wr_data_o, sdr_wr_en_n_o);
          sdr_wr_next_i = 1'b1;
        end else begin
          sdr_rd_data_i  = model_read(a);
          sdr_rd_valid_i = 1'b1;
        end
        @(negedge sdram_clk);
        sdr_wr_next_i  = 1'b0;
        sdr_rd_valid_i = 1'b0;
        model_busy     = 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : stimulus
    logic ack_seen;
    wb_clk_i  = 1'b1;
    wb_stb_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    exp_dat   = '0;
    done      = 1'b0;
    hold_ack  = 1'b0;
    // op, address, data, selects, gap, expected read word
    add_entry(OP_RD,   26'h000_0010, 32'h0,         4'h0, 2, 32'h5a5a_0010);
    add_entry(OP_WR,   26'h000_0010, 32'h1122_3344, 4'hf, 1, 32'h0);
    add_entry(OP_RD,   26'h000_0010, 32'h0,         4'h0, 0, 32'h1122_3344);
    add_entry(OP_WR,   26'h000_0020, 32'haabb_ccdd, 4'h3, 0, 32'h0);
    add_entry(OP_RD,   26'h000_0020, 32'h0,         4'h0, 3, 32'h5a5a_ccdd);
    add_entry(OP_WR,   26'h000_0020, 32'h1234_5678, 4'h8, 1, 32'h0);
    add_entry(OP_RD,   26'h000_0020, 32'h0,         4'h0, 0, 32'h125a_ccdd);
    add_entry(OP_WR,   26'h3ff_ff00, 32'hdead_beef, 4'h6, 0, 32'h0);
    add_entry(OP_RD,   26'h3ff_ff00, 32'h0,         4'h0, 2, 32'h59ad_be00);
    // controller stalls, command FIFO fills up
    add_entry(OP_HOLD, 26'h0,        32'h0,         4'h0, 0, 32'h0);
    add_entry(OP_WR,   26'h000_0100, 32'ha000_0000, 4'hf, 0, 32'h0);
    add_entry(OP_WR,   26'h000_0101, 32'ha000_0001, 4'hf, 0, 32'h0);
    add_entry(OP_WR,   26'h000_0102, 32'ha000_0002, 4'hf, 0, 32'h0);
    add_entry(OP_WR,   26'h000_0103, 32'ha000_0003, 4'hf, 0, 32'h0);
    add_entry(OP_WR,   26'h000_0104, 32'ha000_0004, 4'hf, 0, 32'h0);
    add_entry(OP_WR,   26'h000_0105, 32'ha000_0005, 4'hf, 0, 32'h0);
    add_entry(OP_RD,   26'h000_0103, 32'h0,         4'h0, 1, 32'ha000_0003);
    add_entry(OP_RD,   26'h000_0105, 32'h0,         4'h0, 0, 32'ha000_0005);
    add_entry(OP_RD,   26'h000_1234, 32'h0,         4'h0, 2, 32'h5a5a_1234);
    add_entry(OP_WR,   26'h200_0000, 32'hcafe_f00d, 4'hf, 0, 32'h0);
    add_entry(OP_RD,   26'h200_0000, 32'h0,         4'h0, 1, 32'hcafe_f00d);
    repeat (4) @(posedge sdram_clk);
    @(negedge sdram_clk);
    wb_clk_i = 1'b0;
    repeat (2) @(negedge sdram_clk);
    for (int i = 0; i < n_stim; i++) begin
      if (stim[i].op == OP_HOLD) begin
        hold_ack = 1'b1;
        fork
          begin
            repeat (HOLD_CYCLES) @(negedge sdram_clk);
            hold_ack = 1'b0;
          end
        join_none
      end else begin
        wb_stb_i  = 1'b1;
        wb_cyc_i  = 1'b1;
        wb_we_i   = (stim[i].op == OP_WR);
        wb_addr_i = stim[i].addr;
        wb_dat_i  = stim[i].data;
        wb_sel_i  = stim[i].sel;
        exp_dat   = stim[i].exp;
        // hold the cycle until acked
        ack_seen = 1'b0;
        while (!ack_seen) begin
          @(posedge sdram_clk);
          ack_seen = wb_ack_o;
        end
        @(negedge sdram_clk);
        wb_stb_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_we_i  = 1'b0;
        repeat (stim[i].gap) @(negedge sdram_clk);
      end
    end
    // let queued commands drain
    while (sdr_req_o || model_busy) @(negedge sdram_clk);
    repeat (4) @(negedge sdram_clk);
    done = 1'b1;
    repeat (2) @(negedge sdram_clk);
    $display("errors: %0d mismatch, %0d protocol", mismatch_cnt, fault_cnt);
    if (mismatch_cnt == 0 && fault_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial begin : watchdog
    repeat (NUM_ENTRIES * 200) @(posedge sdram_clk);
    $display("timeout: run did not finish within %0d cycles", NUM_ENTRIES * 200);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
common/wb_bus_pkg.sv
common/sdr_ctrl_pkg.sv
logic/sync_fifo.sv
logic/wb_slave_ctrl.sv
request/request_path.sv
response/read_return_path.sv
logic/wb2sdrc_bridge.sv
testbench/wb2sdrc_checker.sv
testbench/tb_wb2sdrc.sv
